//--- tb.f
+incdir+design
design/fetch_pkg.sv
design/fetch_ifs.sv
design/fetch_ctrl.sv
design/l1i_cache.sv
design/branch_target_buffer.sv
design/fetch_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_model.sv
verification/tb_fetch.sv

//--- Bender.yml
package:
  name: fetch_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/fetch_pkg.sv
      - design/fetch_ifs.sv
      - design/fetch_ctrl.sv
      - design/l1i_cache.sv
      - design/branch_target_buffer.sv
      - design/fetch_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_mem_model.sv
      - verification/tb_fetch.sv

//--- verification/tb_fetch.sv
`include "fetch_consts.svh"

module tb_fetch;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  typedef enum int {C_PLAIN, C_CTRL, C_LOAD, C_FENCE, C_PRED_GOOD, C_PRED_BAD} class_e;

  localparam int  N_ROWS    = 17;
  localparam int  EXP_READS = 12; // lines 0..2, then lines 2, 3 and 0 again after fence.i.
  localparam pc_t BASE      = `FETCH_PC_INIT;

  logic        clk;
  logic        rst;
  logic        ready_i;
  logic        resolve_i;
  logic        resolve_redirect_i;
  pc_t         resolve_pc_i;
  pc_t         resolve_target_i;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;
  logic [31:0] inst_o;
  pc_t         pc_o;
  pc_t         mem_araddr_o;
  logic        valid_o;
  logic        speculation_o;
  logic        good_speculation_o;
  logic        bad_speculation_o;
  logic        mem_arvalid_o;

  // architectural trace, one row per executed instruction.
  pc_t         row_pc     [N_ROWS];
  inst_word_u  row_inst   [N_ROWS];
  class_e      row_cls    [N_ROWS];
  logic        row_taken  [N_ROWS];
  pc_t         row_target [N_ROWS];
  pc_t         row_pred   [N_ROWS];
  int          row_hold   [N_ROWS]; // cycles ready_i stays low once the row is next.
  logic [31:0] image      [8];

  int          row;
  int          low_left;
  int          n_reads;
  int          n_good;
  int          n_bad;
  logic        wp;
  pc_t         wp_pc;
  logic        stall_on;
  pc_t         stall_pc;
  logic        spec_due;
  logic        held;
  pc_t         held_pc;
  logic [31:0] held_inst;
  logic        bad_prev;
  pc_t         line_addr;
  logic        after_rsp;
  logic        res_v   [3];
  logic        res_red [3];
  pc_t         res_pc  [3];
  pc_t         res_tgt [3];

  tb_clock_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  tb_mem_model u_mem (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (mem_arvalid_o),
    .araddr_i  (mem_araddr_o),
    .rvalid_o  (mem_rvalid_i),
    .rdata_o   (mem_rdata_i)
  );

  fetch_top DUT (
    .clk                (clk),
    .rst                (rst),
    .ready_i            (ready_i),
    .resolve_i          (resolve_i),
    .resolve_redirect_i (resolve_redirect_i),
    .resolve_pc_i       (resolve_pc_i),
    .resolve_target_i   (resolve_target_i),
    .mem_rvalid_i       (mem_rvalid_i),
    .mem_rdata_i        (mem_rdata_i),
    .inst_o             (inst_o),
    .pc_o               (pc_o),
    .valid_o            (valid_o),
    .speculation_o      (speculation_o),
    .good_speculation_o (good_speculation_o),
    .bad_speculation_o  (bad_speculation_o),
    .mem_arvalid_o      (mem_arvalid_o),
    .mem_araddr_o       (mem_araddr_o)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "stopping after a mismatch");
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "stopping after a protocol failure");
  endtask

  task automatic set_row(input int i, input logic [4:0] ofs, input logic [31:0] inst,
                         input class_e cls, input logic taken, input logic [4:0] tgt,
                         input logic [4:0] pred, input int hold);
    row_pc[i]       = BASE + ofs;
    row_inst[i].raw = inst;
    row_cls[i]      = cls;
    row_taken[i]    = taken;
    row_target[i]   = BASE + tgt;
    row_pred[i]     = BASE + pred;
    row_hold[i]     = hold;
    image[ofs[4:2]] = inst;
  endtask

  task automatic build_table();
    pc_t addr;
    for (int i = 0; i < 8; i++) begin
      addr     = BASE + 4 * i;
      image[i] = {addr[31:7] ^ addr[24:0], 7'b0010011}; // plain op-imm words outside the trace.
    end
    set_row(0,  5'h00, 32'h0010_8093, C_PLAIN,     1'b0, 5'h00, 5'h00, 0);
    set_row(1,  5'h04, 32'h0021_0113, C_PLAIN,     1'b0, 5'h00, 5'h00, 2);
    set_row(2,  5'h08, 32'h0000_2183, C_LOAD,      1'b0, 5'h00, 5'h00, 0);
    set_row(3,  5'h0c, 32'h0031_8193, C_PLAIN,     1'b0, 5'h00, 5'h00, 1);
    set_row(4,  5'h10, 32'hfe20_9ae3, C_CTRL,      1'b1, 5'h04, 5'h00, 0);
    set_row(5,  5'h04, 32'h0021_0113, C_PLAIN,     1'b0, 5'h00, 5'h00, 0);
    set_row(6,  5'h08, 32'h0000_2183, C_LOAD,      1'b0, 5'h00, 5'h00, 3);
    set_row(7,  5'h0c, 32'h0031_8193, C_PLAIN,     1'b0, 5'h00, 5'h00, 0);
    set_row(8,  5'h10, 32'hfe20_9ae3, C_PRED_GOOD, 1'b1, 5'h04, 5'h04, 0);
    set_row(9,  5'h04, 32'h0021_0113, C_PLAIN,     1'b0, 5'h00, 5'h00, 0);
    set_row(10, 5'h08, 32'h0000_2183, C_LOAD,      1'b0, 5'h00, 5'h00, 0);
    set_row(11, 5'h0c, 32'h0031_8193, C_PLAIN,     1'b0, 5'h00, 5'h00, 2);
    set_row(12, 5'h10, 32'hfe20_9ae3, C_PRED_BAD,  1'b0, 5'h00, 5'h04, 0);
    set_row(13, 5'h14, `INST_FENCE_I, C_FENCE,     1'b0, 5'h00, 5'h00, 0);
    set_row(14, 5'h18, 32'hfe9f_f06f, C_CTRL,      1'b1, 5'h00, 5'h00, 1);
    set_row(15, 5'h00, 32'h0010_8093, C_PLAIN,     1'b0, 5'h00, 5'h00, 0);
    set_row(16, 5'h04, 32'h0021_0113, C_PLAIN,     1'b0, 5'h00, 5'h00, 2);
  endtask

  task automatic drive_inputs();
    for (int k = 0; k < 2; k++) begin
      res_v[k]   = res_v[k+1];
      res_red[k] = res_red[k+1];
      res_pc[k]  = res_pc[k+1];
      res_tgt[k] = res_tgt[k+1];
    end
    res_v[2]           = 1'b0;
    resolve_i          = res_v[0];
    resolve_redirect_i = res_red[0];
    resolve_pc_i       = res_pc[0];
    resolve_target_i   = res_tgt[0];
    ready_i            = (low_left == 0);
    if (low_left > 0) low_left--;
  endtask

  task automatic take_instruction();
    if (stall_on) begin
      report_failure($sformatf("instruction at %h taken before %h was resolved", pc_o, stall_pc));
    end
    if (wp) begin
      // wrong path after a bad prediction runs on from the predicted target.
      check_value("pc_o", pc_o, wp_pc);
      check_value("inst_o", inst_o, image[wp_pc[4:2]]);
      wp_pc = wp_pc + 32'd4;
    end else begin
      check_value("pc_o", pc_o, row_pc[row]);
      check_value("inst_o", inst_o, row_inst[row].raw);
      if (row_cls[row] != C_PLAIN) begin
        res_v[2]   = 1'b1; // backend answers two cycles later.
        res_red[2] = row_taken[row];
        res_pc[2]  = row_pc[row];
        res_tgt[2] = row_target[row];
      end
      if (row_cls[row] == C_CTRL || row_cls[row] == C_LOAD || row_cls[row] == C_FENCE) begin
        stall_on = 1'b1;
        stall_pc = row_pc[row];
      end
      if (row_cls[row] == C_PRED_GOOD || row_cls[row] == C_PRED_BAD) spec_due = 1'b1;
      if (row_cls[row] == C_PRED_BAD) begin
        wp    = 1'b1;
        wp_pc = row_pred[row];
      end
      row++;
      if (row < N_ROWS) low_left = row_hold[row];
    end
  endtask

  task automatic sample_outputs();
    if (spec_due) begin
      check_value("speculation_o", speculation_o, 32'd1);
      spec_due = 1'b0;
    end
    if (held) begin
      check_value("pc_o", pc_o, held_pc);
      if (valid_o) check_value("inst_o", inst_o, held_inst);
    end
    held      = valid_o & !ready_i;
    held_pc   = pc_o;
    held_inst = inst_o;
    if (valid_o && ready_i) take_instruction();
    if (resolve_i && stall_on && resolve_pc_i == stall_pc) stall_on = 1'b0;
    if (good_speculation_o) n_good++;
    if (bad_speculation_o && !bad_prev) begin
      n_bad++;
      wp = 1'b0;
    end
    bad_prev = bad_speculation_o;
  endtask

  // each refill reads the aligned line base first and base + 4 second.
  always @(negedge clk) begin
    if (!rst && after_rsp) begin
      check_value("mem_arvalid_o", mem_arvalid_o, 32'd0); // request drops after a response.
    end
    after_rsp = !rst && mem_rvalid_i;
    if (!rst && mem_rvalid_i) begin
      check_value("mem_arvalid_o", mem_arvalid_o, 32'd1);
      check_value("mem_araddr_o", {mem_araddr_o[31:5], 5'b0}, BASE);
      if (n_reads % 2 == 0) begin
        check_value("mem_araddr_o[2:0]", mem_araddr_o[2:0], 32'd0);
        line_addr = mem_araddr_o;
      end else begin
        check_value("mem_araddr_o", mem_araddr_o, line_addr + 32'd4);
      end
      n_reads++;
    end
  end

  initial begin : watchdog
    repeat (N_ROWS * 40) @(posedge clk);
    $display("timeout: the fetch trace did not complete within %0d cycles", N_ROWS * 40);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin : main_flow
    ready_i            = 1'b0;
    resolve_i          = 1'b0;
    resolve_redirect_i = 1'b0;
    resolve_pc_i       = '0;
    resolve_target_i   = '0;
    n_reads            = 0;
    after_rsp          = 1'b0;
    build_table();
    for (int i = 0; i < 8; i++) u_mem.words[i] = image[i];
    for (int k = 0; k < 3; k++) begin
      res_v[k]   = 1'b0;
      res_red[k] = 1'b0;
      res_pc[k]  = '0;
      res_tgt[k] = '0;
    end
    row      = 0;
    low_left = row_hold[0];
    wp       = 1'b0;
    stall_on = 1'b0;
    spec_due = 1'b0;
    held     = 1'b0;
    bad_prev = 1'b0;
    n_good   = 0;
    n_bad    = 0;
    wait (rst == 1'b0);
    @(negedge clk);
    check_value("pc_o", pc_o, BASE);
    check_value("valid_o", valid_o, 32'd0);
    check_value("speculation_o", speculation_o, 32'd0);
    check_value("good_speculation_o", good_speculation_o, 32'd0);
    check_value("bad_speculation_o", bad_speculation_o, 32'd0);
    while (row < N_ROWS) begin
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      sample_outputs();
    end
    check_value("read count", n_reads, EXP_READS);
    check_value("good_speculation_o pulses", n_good, 32'd1);
    check_value("bad_speculation_o events", n_bad, 32'd1);
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- verification/tb_mem_model.sv
module tb_mem_model (
  input  logic           clk,
  input  logic           rst,
  input  logic           arvalid_i,
  input  fetch_pkg::pc_t araddr_i,
  output logic           rvalid_o,
  output logic [31:0]    rdata_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  logic [31:0] words [8]; // 32-byte program region, filled by the testbench top.
  logic [31:0] lfsr;

  // fibonacci form with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  initial begin : responder
    logic busy;
    logic fire;
    logic b0;
    logic b1;
    int   cnt;
    pc_t  addr;
    rvalid_o = 1'b0;
    rdata_o  = 32'h0;
    lfsr     = 32'hc154;
    busy     = 1'b0;
    cnt      = 0;
    addr     = '0;
    forever begin
      @(negedge clk);
      fire = 1'b0;
      if (rst) begin
        busy = 1'b0;
      end else if (busy) begin
        cnt = cnt - 1;
        if (cnt == 0) begin
          fire = 1'b1;
          busy = 1'b0;
        end
      end else if (arvalid_i && !rvalid_o) begin
        busy = 1'b1;
        addr = araddr_i;
        b0   = lfsr[31];
        lfsr = lfsr_step(lfsr);
        b1   = lfsr[31];
        lfsr = lfsr_step(lfsr);
        cnt  = 1 + {b1, b0}; // 1 to 4 cycles.
      end
      @(posedge clk);
      #1;
      rvalid_o = fire;
      rdata_o  = fire ? words[addr[4:2]] : 32'h0;
    end
  end

endmodule

//--- verification/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // reset is released shortly after the 16th rising edge.
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

//--- design/fetch_top.sv
module fetch_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           ready_i,
  input  logic           resolve_i,
  input  logic           resolve_redirect_i,
  input  fetch_pkg::pc_t resolve_pc_i,
  input  fetch_pkg::pc_t resolve_target_i,
  input  logic           mem_rvalid_i,
  input  logic [31:0]    mem_rdata_i,
  output logic [31:0]    inst_o,
  output fetch_pkg::pc_t pc_o,
  output logic           valid_o,
  output logic           speculation_o,
  output logic           good_speculation_o,
  output logic           bad_speculation_o,
  output logic           mem_arvalid_o,
  output fetch_pkg::pc_t mem_araddr_o
);

  icache_if cache_bus ();
  btb_if    btb_bus ();

  assign inst_o = cache_bus.inst.raw;

  fetch_ctrl u_fetch_ctrl (
    .clk                (clk),
    .rst                (rst),
    .cache              (cache_bus.ctrl),
    .btb                (btb_bus.ctrl),
    .ready_i            (ready_i),
    .resolve_i          (resolve_i),
    .resolve_redirect_i (resolve_redirect_i),
    .resolve_pc_i       (resolve_pc_i),
    .resolve_target_i   (resolve_target_i),
    .pc_o               (pc_o),
    .valid_o            (valid_o),
    .speculation_o      (speculation_o),
    .good_speculation_o (good_speculation_o),
    .bad_speculation_o  (bad_speculation_o)
  );

  l1i_cache u_l1i_cache (
    .clk           (clk),
    .rst           (rst),
    .cache         (cache_bus.cache),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  branch_target_buffer u_btb (
    .clk (clk),
    .rst (rst),
    .btb (btb_bus.btb)
  );

endmodule

//--- design/branch_target_buffer.sv
`include "fetch_consts.svh"

module branch_target_buffer (
  input logic clk,
  input logic rst,
  btb_if.btb  btb
);
  import fetch_pkg::*;

  logic [`BTB_ENTRIES-1:0] valid_q;
  logic [`BTB_TAG_W-1:0]   tag_q    [`BTB_ENTRIES];
  pc_t                     target_q [`BTB_ENTRIES];

  logic [`BTB_ENTRIES_LOG2-1:0] lk_idx;
  logic [`BTB_TAG_W-1:0]        lk_tag;
  logic [`BTB_ENTRIES_LOG2-1:0] up_idx;
  logic [`BTB_TAG_W-1:0]        up_tag;

  assign lk_idx = btb.lookup_pc[`BTB_ENTRIES_LOG2+1:2];
  assign lk_tag = btb.lookup_pc[31:`BTB_ENTRIES_LOG2+2];
  assign up_idx = btb.upd_pc[`BTB_ENTRIES_LOG2+1:2];
  assign up_tag = btb.upd_pc[31:`BTB_ENTRIES_LOG2+2];

  assign btb.hit    = valid_q[lk_idx] & (tag_q[lk_idx] == lk_tag);
  assign btb.target = target_q[lk_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (btb.upd_valid) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  // a newer branch simply evicts whatever shares its index.
  always_ff @(posedge clk) begin
    if (btb.upd_valid) begin
      tag_q[up_idx]    <= up_tag;
      target_q[up_idx] <= btb.upd_target;
    end
  end

endmodule

//--- design/l1i_cache.sv
`include "fetch_consts.svh"

module l1i_cache (
  input  logic           clk,
  input  logic           rst,
  icache_if.cache        cache,
  output logic           mem_arvalid_o,
  output fetch_pkg::pc_t mem_araddr_o,
  input  logic           mem_rvalid_i,
  input  logic [31:0]    mem_rdata_i
);
  import fetch_pkg::*;

  localparam int OFS_LSB = 2;
  localparam int IDX_LSB = OFS_LSB + `L1I_LINE_WORDS_LOG2;
  localparam int TAG_LSB = IDX_LSB + `L1I_SETS_LOG2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WORD0,
    ST_WORD1,
    ST_DONE
  } state_e;

  state_e                state_q;
  logic [`L1I_SETS-1:0]  valid_q;
  logic                  rsp_q;  // a response arrived in the previous cycle.
  pc_t                   base_q; // line base of the refill in progress.

  logic [31:0]           data_q [`L1I_SETS][`L1I_LINE_WORDS];
  logic [`L1I_TAG_W-1:0] tag_q  [`L1I_SETS][`L1I_LINE_WORDS];

  logic [`L1I_SETS_LOG2-1:0]       rd_idx;
  logic [`L1I_LINE_WORDS_LOG2-1:0] rd_ofs;
  logic [`L1I_TAG_W-1:0]           rd_tag;
  logic [`L1I_SETS_LOG2-1:0]       fill_idx;
  logic [`L1I_TAG_W-1:0]           fill_tag;
  pc_t                             line_base;
  logic                            match;

  assign rd_idx    = cache.pc[TAG_LSB-1:IDX_LSB];
  assign rd_ofs    = cache.pc[IDX_LSB-1:OFS_LSB];
  assign rd_tag    = cache.pc[31:TAG_LSB];
  assign line_base = {cache.pc[31:IDX_LSB], {IDX_LSB{1'b0}}};

  assign fill_idx = base_q[TAG_LSB-1:IDX_LSB];
  assign fill_tag = base_q[31:TAG_LSB];

  assign match = valid_q[rd_idx] & (tag_q[rd_idx][rd_ofs] == rd_tag);

  assign cache.hit      = ((state_q == ST_IDLE) | (state_q == ST_DONE)) & match;
  assign cache.idle     = (state_q == ST_IDLE);
  assign cache.inst.raw = data_q[rd_idx][rd_ofs];

  // the request drops for one cycle after each response.
  assign mem_arvalid_o = !rsp_q & (((state_q == ST_IDLE) & !match) |
                                   (state_q == ST_WORD0) | (state_q == ST_WORD1));
  assign mem_araddr_o  = (state_q == ST_IDLE)  ? line_base :
                         (state_q == ST_WORD1) ? base_q + 32'd4 : base_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      valid_q <= '0;
      rsp_q   <= 1'b0;
    end else begin
      rsp_q <= mem_rvalid_i;
      case (state_q)
        ST_IDLE: begin
          if (cache.flush) begin
            valid_q <= '0;
          end else if (!match) begin
            state_q <= ST_WORD0;
          end
        end
        ST_WORD0: begin
          if (mem_rvalid_i) begin
            state_q <= ST_WORD1;
          end
        end
        ST_WORD1: begin
          if (mem_rvalid_i) begin
            state_q           <= ST_DONE;
            valid_q[fill_idx] <= 1'b1;
          end
        end
        ST_DONE: begin
          if (cache.flush) begin
            valid_q <= '0; // fence.i may be taken in the cycle it first hits.
          end
          state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE) begin
      base_q <= line_base;
    end
    if (mem_rvalid_i & (state_q == ST_WORD0)) begin
      data_q[fill_idx][0] <= mem_rdata_i;
      tag_q[fill_idx][0]  <= fill_tag;
    end
    if (mem_rvalid_i & (state_q == ST_WORD1)) begin
      data_q[fill_idx][1] <= mem_rdata_i;
      tag_q[fill_idx][1]  <= fill_tag;
    end
  end

endmodule

//--- design/fetch_ctrl.sv
`include "fetch_consts.svh"

module fetch_ctrl (
  input  logic           clk,
  input  logic           rst,
  icache_if.ctrl         cache,
  btb_if.ctrl            btb,
  input  logic           ready_i,
  input  logic           resolve_i,
  input  logic           resolve_redirect_i,
  input  fetch_pkg::pc_t resolve_pc_i,
  input  fetch_pkg::pc_t resolve_target_i,
  output fetch_pkg::pc_t pc_o,
  output logic           valid_o,
  output logic           speculation_o,
  output logic           good_speculation_o,
  output logic           bad_speculation_o
);
  import fetch_pkg::*;

  pc_t  pc_q;
  logic hazard_q;
  logic speculation_q;
  logic bad_q;
  logic good_q;

  pc_t  pred_target_q;
  pc_t  fall_through_q;
  logic cond_q;         // the speculated instruction is a conditional branch.
  pc_t  redirect_pc_q;

  logic [6:0] opcode;
  logic is_ctrl;
  logic is_load;
  logic is_store;
  logic is_fence;
  logic take;
  logic predict;
  logic good_now;
  logic bad_now;
  logic redirect;
  logic hazard_clear;
  pc_t  fall_pc;
  pc_t  actual_npc;

  assign opcode   = cache.inst.fields.opcode;
  assign is_ctrl  = (opcode == `OP_JAL) | (opcode == `OP_JALR) |
                    (opcode == `OP_BRANCH) | (opcode == `OP_SYSTEM);
  assign is_load  = (opcode == `OP_LOAD);
  assign is_store = (opcode == `OP_STORE);
  assign is_fence = (cache.inst.raw == `INST_FENCE_I);

  // the architectural successor of the instruction being resolved.
  assign fall_pc    = (speculation_q & cond_q) ? fall_through_q : resolve_pc_i + 32'd4;
  assign actual_npc = resolve_redirect_i ? resolve_target_i : fall_pc;

  assign good_now = speculation_q & resolve_i & (actual_npc == pred_target_q);
  assign bad_now  = speculation_q & resolve_i & (actual_npc != pred_target_q);

  assign bad_speculation_o  = bad_q | bad_now;
  assign good_speculation_o = good_q;
  assign speculation_o      = speculation_q;

  // memory accesses on a predicted path wait until the prediction is settled.
  assign valid_o = cache.hit & !hazard_q & !bad_speculation_o &
                   !(speculation_q & (is_load | is_store));
  assign take    = valid_o & ready_i;
  assign predict = take & is_ctrl & btb.hit & !speculation_q;

  assign redirect     = bad_q & ready_i & cache.idle;
  assign hazard_clear = hazard_q & resolve_i & !speculation_q & !bad_q;

  assign pc_o        = pc_q;
  assign cache.pc    = pc_q;
  assign cache.flush = take & is_fence;

  assign btb.lookup_pc  = pc_q;
  assign btb.upd_valid  = resolve_i & resolve_redirect_i; // only taken targets are learned.
  assign btb.upd_pc     = resolve_pc_i;
  assign btb.upd_target = resolve_target_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q          <= `FETCH_PC_INIT;
      hazard_q      <= 1'b0;
      speculation_q <= 1'b0;
      bad_q         <= 1'b0;
      good_q        <= 1'b0;
    end else begin
      good_q <= good_now;
      if (good_now | bad_now) begin
        speculation_q <= 1'b0;
      end
      if (bad_now) begin
        bad_q <= 1'b1;
      end

      if (redirect) begin
        // leave the wrong path, this also drops a hazard raised on it.
        bad_q    <= 1'b0;
        hazard_q <= 1'b0;
        pc_q     <= redirect_pc_q;
      end else if (hazard_clear) begin
        hazard_q <= 1'b0;
        pc_q     <= actual_npc;
      end else if (take) begin
        if (predict) begin
          pc_q          <= btb.target;
          speculation_q <= 1'b1;
        end else if (is_ctrl | is_load | is_fence) begin
          hazard_q <= 1'b1; // pc stays put until the backend resolves.
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (predict) begin
      pred_target_q  <= btb.target;
      fall_through_q <= pc_q + 32'd4;
      cond_q         <= (opcode == `OP_BRANCH);
    end
    if (bad_now) begin
      redirect_pc_q <= actual_npc;
    end
  end

endmodule

//--- design/fetch_ifs.sv
// link between the fetch controller and the L1 instruction cache.
interface icache_if;
  import fetch_pkg::*;

  pc_t        pc;
  logic       hit;   // word at pc is present and usable this cycle.
  inst_word_u inst;
  logic       idle;
  logic       flush; // one-cycle pulse, drops every line.

  modport ctrl (
    output pc,
    output flush,
    input  hit,
    input  inst,
    input  idle
  );

  modport cache (
    input  pc,
    input  flush,
    output hit,
    output inst,
    output idle
  );
endinterface

// link between the fetch controller and the branch target buffer.
interface btb_if;
  import fetch_pkg::*;

  pc_t  lookup_pc;
  logic hit;
  pc_t  target;
  logic upd_valid;
  pc_t  upd_pc;
  pc_t  upd_target;

  modport ctrl (
    output lookup_pc,
    output upd_valid,
    output upd_pc,
    output upd_target,
    input  hit,
    input  target
  );

  modport btb (
    input  lookup_pc,
    input  upd_valid,
    input  upd_pc,
    input  upd_target,
    output hit,
    output target
  );
endinterface

//--- design/fetch_pkg.sv
package fetch_pkg;

  // instruction address, also used for targets and bus addresses.
  typedef logic [31:0] pc_t;

  // split of an instruction word as seen by the opcode decoder.
  typedef struct packed {
    logic [24:0] upper;
    logic [6:0]  opcode;
  } inst_fields_t;

  // one fetched word, either as raw data or through its opcode field.
  typedef union packed {
    logic [31:0]  raw;
    inst_fields_t fields;
  } inst_word_u;

endpackage

//--- design/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// reset value of the fetch PC.
`define FETCH_PC_INIT 32'h8000_0000

// RV32 major opcodes that the fetch stage has to tell apart.
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_SYSTEM 7'b1110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011

// fence.i with rd, rs1 and imm all zero.
`define INST_FENCE_I 32'h0000_100f

// L1 instruction cache geometry.
`define L1I_SETS_LOG2       2
`define L1I_LINE_WORDS_LOG2 1
`define L1I_SETS            (1 << `L1I_SETS_LOG2)
`define L1I_LINE_WORDS      (1 << `L1I_LINE_WORDS_LOG2)
`define L1I_TAG_W           (32 - `L1I_SETS_LOG2 - `L1I_LINE_WORDS_LOG2 - 2)

// branch target buffer geometry.
`define BTB_ENTRIES_LOG2 2
`define BTB_ENTRIES      (1 << `BTB_ENTRIES_LOG2)
`define BTB_TAG_W        (32 - `BTB_ENTRIES_LOG2 - 2)

`endif
